// ==== codec_i2c_cfg.svh ====
`ifndef CODEC_I2C_CFG_SVH
`define CODEC_I2C_CFG_SVH

// Codec address 0x1A shifted left, write bit clear
`define CODEC_DEV_ADDR 8'h34

// Writes in the power-up table
`define INIT_CMD_COUNT 7

// System clocks per half SCL period, even and at least 2
`define SCL_HALF_CYCLES 4

`endif

// ==== codec_i2c_init.sv ====
module codec_i2c_init import codec_i2c_pkg::*; (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_start,
    input  logic i_sda_in,
    output logic o_scl,
    output logic o_sda,
    output logic o_sda_oe,
    output logic o_busy,
    output logic o_finished,
    output logic o_error
);

    cmd_idx_t cmd_idx;
    i2c_cmd_t cmd;
    logic     cmd_go;
    logic     xfer_done;
    logic     xfer_nack;
    logic     eng_busy;

    codec_init_sequencer u_seq (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_start     (i_start),
        .i_xfer_done (xfer_done),
        .i_xfer_nack (xfer_nack),
        .o_cmd_idx   (cmd_idx),
        .o_cmd_go    (cmd_go),
        .o_busy      (o_busy),
        .o_finished  (o_finished),
        .o_error     (o_error)
    );

    codec_init_rom u_rom (
        .i_idx (cmd_idx),
        .o_cmd (cmd)
    );

    i2c_write_engine u_eng (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_cmd_go    (cmd_go),
        .i_cmd       (cmd),
        .i_sda_in    (i_sda_in),
        .o_scl       (o_scl),
        .o_sda       (o_sda),
        .o_sda_oe    (o_sda_oe),
        .o_busy      (eng_busy),
        .o_xfer_done (xfer_done),
        .o_xfer_nack (xfer_nack)
    );

    // Bus activity only inside a sequencer run
    a_eng_in_run: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        eng_busy |-> o_busy);

endmodule

// ==== codec_i2c_pkg.sv ====
package codec_i2c_pkg;

    // One codec register write, in bus byte order
    typedef struct packed {
        logic [7:0] dev_addr; // 7-bit address plus write bit
        logic [6:0] reg_addr;
        logic [8:0] reg_data; // Bit 8 rides in the second byte
    } i2c_cmd_t;

    // Index into the power-up register table
    typedef logic [2:0] cmd_idx_t;

    // Engine phase, also used to decode the bus pins
    typedef enum logic [2:0] {
        ENG_IDLE  = 3'd0,
        ENG_START = 3'd1,
        ENG_BIT   = 3'd2,
        ENG_ACK   = 3'd3,
        ENG_STOP  = 3'd4
    } eng_state_t;

endpackage

// ==== codec_init_rom.sv ====
`include "codec_i2c_cfg.svh"

module codec_init_rom import codec_i2c_pkg::*; (
    input  cmd_idx_t i_idx,
    output i2c_cmd_t o_cmd
);

    logic [6:0] reg_addr;
    logic [8:0] reg_data;

    always_comb begin
        case (i_idx)
            3'd0: begin
                reg_addr = 7'h0F; // Reset
                reg_data = 9'h000;
            end
            3'd1: begin
                reg_addr = 7'h04; // Analogue path
                reg_data = 9'h015;
            end
            3'd2: begin
                reg_addr = 7'h05; // Digital path
                reg_data = 9'h000;
            end
            3'd3: begin
                reg_addr = 7'h06; // Power down, all on
                reg_data = 9'h000;
            end
            3'd4: begin
                reg_addr = 7'h07; // Interface format
                reg_data = 9'h042;
            end
            3'd5: begin
                reg_addr = 7'h08; // Sampling
                reg_data = 9'h019;
            end
            default: begin
                reg_addr = 7'h09; // Active control
                reg_data = 9'h001;
            end
        endcase
    end

    assign o_cmd = '{dev_addr: `CODEC_DEV_ADDR, reg_addr: reg_addr, reg_data: reg_data};

endmodule

// ==== codec_init_sequencer.sv ====
`include "codec_i2c_cfg.svh"

module codec_init_sequencer import codec_i2c_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_start,
    input  logic     i_xfer_done,
    input  logic     i_xfer_nack,
    output cmd_idx_t o_cmd_idx,
    output logic     o_cmd_go,
    output logic     o_busy,
    output logic     o_finished,
    output logic     o_error
);

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_WAIT
    } seq_state_t;

    seq_state_t state;
    cmd_idx_t   idx;
    logic       finished_r;
    logic       error_r;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state      <= SEQ_IDLE;
            idx        <= '0;
            finished_r <= 1'b0;
            error_r    <= 1'b0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (i_start) begin        // Restart always from entry 0
                        state      <= SEQ_ISSUE;
                        idx        <= '0;
                        finished_r <= 1'b0;
                        error_r    <= 1'b0;
                    end
                end
                SEQ_ISSUE: state <= SEQ_WAIT; // Go lasts this one cycle
                SEQ_WAIT: begin
                    if (i_xfer_done) begin
                        if (i_xfer_nack) begin
                            error_r <= 1'b1;  // Failing index kept
                            state   <= SEQ_IDLE;
                        end else if (idx == cmd_idx_t'(`INIT_CMD_COUNT - 1)) begin
                            finished_r <= 1'b1;
                            state      <= SEQ_IDLE;
                        end else begin
                            idx   <= idx + 1'b1;
                            state <= SEQ_ISSUE;
                        end
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
        end
    end

    assign o_cmd_idx  = idx;
    assign o_cmd_go   = (state == SEQ_ISSUE);
    assign o_busy     = (state != SEQ_IDLE);
    assign o_finished = finished_r;
    assign o_error    = error_r;

    a_one_outcome: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_finished && o_error));

endmodule

// ==== i2c_slave_model.sv ====
module i2c_slave_model (
    input  logic i_clk,
    input  logic i_clear,
    input  logic i_scl,
    input  logic i_sda,        // Resolved bus line
    input  int   i_nack_byte,  // Byte number left unacknowledged, 0 for none
    output logic o_pull,
    output logic o_proto_err
);

    logic [7:0] byte_q [$];      // Every byte seen, in bus order
    int         frame_len_q [$]; // Bytes per frame, pushed at stop
    logic       prev_scl  = 1'b1;
    logic       prev_sda  = 1'b1;
    logic       in_frame  = 1'b0;
    logic       pull      = 1'b0;
    logic       proto_err = 1'b0;
    logic [6:0] shreg     = '0;
    int         bit_cnt   = 0;   // 8 means the acknowledge slot is next
    int         byte_cnt  = 0;
    int         cur_len   = 0;

    assign o_pull      = pull;
    assign o_proto_err = proto_err;

    // Lines sampled on the system clock, edges found against the last sample
    always @(posedge i_clk) begin
        prev_scl <= i_scl;
        prev_sda <= i_sda;
        if (i_clear) begin
            byte_q.delete();
            frame_len_q.delete();
            in_frame  <= 1'b0;
            bit_cnt   <= 0;
            byte_cnt  <= 0;
            cur_len   <= 0;
            pull      <= 1'b0;
            proto_err <= 1'b0;
        end else if (prev_scl && i_scl && prev_sda && !i_sda) begin
            if (in_frame)
                proto_err <= 1'b1; // No repeated start expected
            in_frame <= 1'b1;
            bit_cnt  <= 0;
            cur_len  <= 0;
        end else if (prev_scl && i_scl && !prev_sda && i_sda) begin
            // Stop only on the first SCL rise of a new byte
            if (!in_frame || bit_cnt != 1)
                proto_err <= 1'b1;
            in_frame <= 1'b0;
            frame_len_q.push_back(cur_len);
        end else if (!prev_scl && i_scl) begin
            if (!in_frame)
                proto_err <= 1'b1;
            if (bit_cnt < 8) begin
                shreg   <= {shreg[5:0], i_sda};
                bit_cnt <= bit_cnt + 1;
                if (bit_cnt == 7) begin
                    byte_q.push_back({shreg, i_sda});
                    byte_cnt <= byte_cnt + 1;
                    cur_len  <= cur_len + 1;
                end
            end else begin
                bit_cnt <= 0; // Acknowledge slot clocked
            end
        end else if (prev_scl && !i_scl) begin
            pull <= (bit_cnt == 8) && (byte_cnt != i_nack_byte);
        end
    end

endmodule

// ==== i2c_write_engine.sv ====
`include "codec_i2c_cfg.svh"

module i2c_write_engine import codec_i2c_pkg::*; (
    input  logic     i_clk,
    input  logic     i_rst_n,
    input  logic     i_cmd_go,
    input  i2c_cmd_t i_cmd,
    input  logic     i_sda_in,
    output logic     o_scl,
    output logic     o_sda,
    output logic     o_sda_oe,
    output logic     o_busy,
    output logic     o_xfer_done,
    output logic     o_xfer_nack
);

    localparam int QTR   = `SCL_HALF_CYCLES / 2;        // Clocks per quarter slot
    localparam int DIV_W = (QTR > 1) ? $clog2(QTR) : 1;

    eng_state_t       state;
    logic [DIV_W-1:0] div_cnt;
    logic             tick;
    logic [2:0]       qtr;      // Quarter within slot, 0..7 for start and stop
    logic [2:0]       last_qtr;
    logic [4:0]       bit_cnt;  // Payload bits already sent
    logic [23:0]      shreg;
    logic             nack_r;
    logic             done_r;

    assign tick     = (div_cnt == DIV_W'(QTR - 1));
    assign last_qtr = (state == ENG_START || state == ENG_STOP) ? 3'd7 : 3'd3;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state   <= ENG_IDLE;
            div_cnt <= '0;
            qtr     <= '0;
            bit_cnt <= '0;
            nack_r  <= 1'b0;
            done_r  <= 1'b0;
        end else begin
            done_r <= 1'b0;
            if (state == ENG_IDLE) begin
                div_cnt <= '0;
                qtr     <= '0;
                if (i_cmd_go) begin
                    state   <= ENG_START;
                    bit_cnt <= '0;
                    nack_r  <= 1'b0;
                end
            end else if (!tick) begin
                div_cnt <= div_cnt + 1'b1;
            end else begin
                div_cnt <= '0;
                qtr     <= qtr + 1'b1;
                if (state == ENG_ACK && qtr == 3'd0)
                    nack_r <= i_sda_in; // Sampled as SCL rises
                if (qtr == last_qtr) begin
                    qtr <= '0;
                    case (state)
                        ENG_START: state <= ENG_BIT;
                        ENG_BIT: begin
                            bit_cnt <= bit_cnt + 1'b1;
                            state   <= (bit_cnt[2:0] == 3'd7) ? ENG_ACK : ENG_BIT;
                        end
                        ENG_ACK: begin
                            // Abort on NACK right after the slot
                            if (nack_r || bit_cnt == 5'd24)
                                state <= ENG_STOP;
                            else
                                state <= ENG_BIT;
                        end
                        ENG_STOP: begin
                            state  <= ENG_IDLE;
                            done_r <= 1'b1;
                        end
                        default: state <= ENG_IDLE;
                    endcase
                end
            end
        end
    end

    // Payload shifter, MSB on the wire
    always_ff @(posedge i_clk) begin
        if (state == ENG_IDLE && i_cmd_go)
            shreg <= i_cmd;
        else if (state == ENG_BIT && tick && qtr == 3'd3)
            shreg <= {shreg[22:0], 1'b0};
    end

    // Bit slot: SDA set in q0, SCL high in q1 and q2, falls in q3
    always_comb begin
        case (state)
            ENG_START: begin
                o_scl    = (qtr != 3'd7);
                o_sda    = (qtr < 3'd4);   // Falls mid phase with SCL high
                o_sda_oe = 1'b1;
            end
            ENG_BIT: begin
                o_scl    = (qtr == 3'd1 || qtr == 3'd2);
                o_sda    = shreg[23];
                o_sda_oe = 1'b1;
            end
            ENG_ACK: begin
                o_scl    = (qtr == 3'd1 || qtr == 3'd2);
                o_sda    = 1'b1;
                o_sda_oe = 1'b0;           // Device drives the slot
            end
            ENG_STOP: begin
                o_scl    = (qtr >= 3'd4);
                o_sda    = (qtr >= 3'd6);  // Rises after SCL is high
                o_sda_oe = 1'b1;
            end
            default: begin
                o_scl    = 1'b1;
                o_sda    = 1'b1;
                o_sda_oe = 1'b0;
            end
        endcase
    end

    assign o_busy      = (state != ENG_IDLE);
    assign o_xfer_done = done_r;
    assign o_xfer_nack = nack_r;

    a_no_go_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_cmd_go |-> !o_busy);

    // Bus released mid-transfer only in the slot after a whole byte
    a_oe_release: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (!o_sda_oe && o_busy) |->
            (state == ENG_ACK && bit_cnt[2:0] == 3'd0 && bit_cnt != 5'd0));

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build the codec init testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -j 0 --top-module tb_codec_i2c_init -f verilog.f -o sim_tb || exit 1
out=$(./obj_dir/sim_tb 2>&1)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "NO ERRORS" && exit 0 || exit 1

// ==== tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int PERIOD     = 10,
    parameter int RST_CYCLES = 4
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // Release just after an edge, like every other input
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        #1;
        o_rst_n = 1'b1;
    end

endmodule

// ==== tb_codec_i2c_init.sv ====
`include "codec_i2c_cfg.svh"

module tb_codec_i2c_init;

    localparam int N_SCEN        = 4;
    localparam int SLOT_CLKS     = 2 * `SCL_HALF_CYCLES;
    localparam int WATCHDOG_TIME = N_SCEN * 8 * 31 * SLOT_CLKS * 10;

    logic clk;
    logic rst_n;
    logic start;
    logic scl;
    logic sda;
    logic sda_oe;
    logic sda_line;
    logic busy;
    logic finished;
    logic error;
    logic pull;
    logic proto_err;
    logic clear;
    int   nack_byte;

    // Codec register map, index order
    logic [6:0] tab_addr [0:6] = '{7'h0F, 7'h04, 7'h05, 7'h06, 7'h07, 7'h08, 7'h09};
    logic [8:0] tab_data [0:6] = '{9'h000, 9'h015, 9'h000, 9'h000, 9'h042, 9'h019, 9'h001};

    // Scenario table
    string scen_name   [N_SCEN] = '{"full_ack", "nack_addr_w3", "nack_data_w7", "restart_full"};
    int    scen_nack   [N_SCEN] = '{0, 7, 21, 0};
    int    scen_err    [N_SCEN] = '{0, 1, 1, 0};
    int    scen_frames [N_SCEN] = '{`INIT_CMD_COUNT, 3, `INIT_CMD_COUNT, `INIT_CMD_COUNT};

    assign sda_line = (sda_oe ? sda : 1'b1) & ~pull; // Open-drain bus

    tb_clock_gen #(.PERIOD(10), .RST_CYCLES(4)) clkgen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    i2c_slave_model slave (
        .i_clk       (clk),
        .i_clear     (clear),
        .i_scl       (scl),
        .i_sda       (sda_line),
        .i_nack_byte (nack_byte),
        .o_pull      (pull),
        .o_proto_err (proto_err)
    );

    codec_i2c_init UUT (
        .i_clk      (clk),
        .i_rst_n    (rst_n),
        .i_start    (start),
        .i_sda_in   (sda_line),
        .o_scl      (scl),
        .o_sda      (sda),
        .o_sda_oe   (sda_oe),
        .o_busy     (busy),
        .o_finished (finished),
        .o_error    (error)
    );

    // Bytes in a frame, shorter where the device refused one
    function automatic int frame_len(int nack, int frame);
        if (nack != 0 && (nack - 1) / 3 == frame)
            return (nack - 1) % 3 + 1;
        return 3;
    endfunction

    function automatic logic [7:0] exp_byte(int idx, int pos);
        case (pos)
            0:       return `CODEC_DEV_ADDR;
            1:       return {tab_addr[idx], tab_data[idx][8]};
            default: return tab_data[idx][7:0];
        endcase
    endfunction

    task automatic next_cycle;
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(string name, string what, int exp, int act);
        assert (exp == act) else begin
            $display("Fail %s %s: expected %0h actual %0h", name, what, exp, act);
            $display("ERRORS FOUND");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    task automatic check_frames(int s);
        int pos;
        int len;
        pos = 0;
        check_value(scen_name[s], "frame count", scen_frames[s], slave.frame_len_q.size());
        for (int f = 0; f < scen_frames[s]; f++) begin
            len = frame_len(scen_nack[s], f);
            check_value(scen_name[s], $sformatf("frame %0d length", f), len,
                        slave.frame_len_q[f]);
            for (int b = 0; b < len; b++) begin
                check_value(scen_name[s], $sformatf("frame %0d byte %0d", f, b),
                            int'(exp_byte(f, b)), int'(slave.byte_q[pos]));
                pos++;
            end
        end
        check_value(scen_name[s], "byte count", pos, slave.byte_q.size());
    endtask

    initial begin
        #(WATCHDOG_TIME);
        $display("Timeout: no finish or error flag after %0d time units", WATCHDOG_TIME);
        $display("ERRORS FOUND");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        start     = 1'b0;
        clear     = 1'b0;
        nack_byte = 0;
        @(posedge rst_n);
        next_cycle();
        check_value("reset", "scl", 1, int'(scl));
        check_value("reset", "sda", 1, int'(sda));
        check_value("reset", "sda_oe", 0, int'(sda_oe));
        check_value("reset", "busy", 0, int'(busy));
        check_value("reset", "finished", 0, int'(finished));
        check_value("reset", "error", 0, int'(error));
        for (int s = 0; s < N_SCEN; s++) begin
            nack_byte = scen_nack[s];
            clear     = 1'b1;
            next_cycle();
            clear = 1'b0;
            start = 1'b1;
            next_cycle();
            start = 1'b0;
            // Old outcome flags drop as the run starts
            check_value(scen_name[s], "busy at start", 1, int'(busy));
            check_value(scen_name[s], "finished at start", 0, int'(finished));
            check_value(scen_name[s], "error at start", 0, int'(error));
            while (!(finished || error))
                next_cycle();
            check_value(scen_name[s], "error", scen_err[s], int'(error));
            check_value(scen_name[s], "finished", 1 - scen_err[s], int'(finished));
            check_value(scen_name[s], "busy at end", 0, int'(busy));
            check_value(scen_name[s], "scl idle", 1, int'(scl));
            check_value(scen_name[s], "sda idle", 1, int'(sda_line));
            check_frames(s);
            assert (!proto_err) else begin
                $display("Device model saw SDA change with SCL high mid-frame in %s",
                         scen_name[s]);
                $display("ERRORS FOUND");
                $fatal(1, "Bus protocol violation");
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+.
codec_i2c_pkg.sv
codec_init_rom.sv
i2c_write_engine.sv
codec_init_sequencer.sv
codec_i2c_init.sv
tb_clock_gen.sv
i2c_slave_model.sv
tb_codec_i2c_init.sv
